/* flist.f */
+incdir+common
common/lc3b_types.sv
eviction_wb/eviction_wb_datapath.sv
eviction_wb/eviction_wb_control.sv
eviction_wb/eviction_wb.sv
source/eviction_regs.sv
source/victim_buffer_top.sv
testbench/pmem_model.sv
testbench/eviction_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module eviction_tb

out=$(./obj_dir/Veviction_tb)
echo "$out"

echo "$out" | grep -qx "test passed"

/* testbench/eviction_tb.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_tb import lc3b_types::*; ();

logic clk;
logic arst_n;
logic cpu_cyc;
logic cpu_stb;
logic cpu_we;
lc3b_line_addr cpu_adr;
lc3b_line_mask cpu_sel;
lc3b_line cpu_dat_w;
lc3b_line cpu_dat_r;
logic cpu_ack;
logic mem_cyc;
logic mem_stb;
logic mem_we;
lc3b_line_addr mem_adr;
lc3b_line_mask mem_sel;
lc3b_line mem_dat_w;
lc3b_line mem_dat_r;
logic mem_ack;
logic cfg_cyc;
logic cfg_stb;
logic cfg_we;
logic [`EWB_REG_ADR_W-1:0] cfg_adr;
logic [`EWB_REG_W-1:0] cfg_dat_w;
logic [`EWB_REG_W-1:0] cfg_dat_r;
logic cfg_ack;

// Reference model
lc3b_line model_mem [1 << `EWB_ADDR_W];
lc3b_line_addr buf_tag [`EWB_ENTRIES];
lc3b_line buf_line [`EWB_ENTRIES];
logic [`EWB_ENTRIES-1:0] buf_valid;
logic [2:0] plru;
logic model_enable;
int model_hits;
lc3b_line_addr touched [$];

// Checker state
logic chk_en;
string chk_name;
logic [127:0] chk_got;
logic [127:0] chk_exp;
int errors;
int checks;
int bad_cases;
int case_err;
logic timed_out;

victim_buffer_top dut_i (.*);

pmem_model pmem_i (
	.clk(clk),
	.arst_n(arst_n),
	.cyc(mem_cyc),
	.stb(mem_stb),
	.we(mem_we),
	.adr(mem_adr),
	.sel(mem_sel),
	.dat_w(mem_dat_w),
	.dat_r(mem_dat_r),
	.ack(mem_ack)
);

always #5 clk = ~clk;

check_value: assert property (@(posedge clk) chk_en |-> chk_got == chk_exp)
	else begin
		errors++;
		$display("Fail %s got %h expected %h", chk_name, chk_got, chk_exp);
	end

always @(posedge timed_out) begin
	$display("test failed");
	$finish;
end

function automatic lc3b_line mem_pattern(input int a);
	logic [31:0] w;
	w = {a[11:0], 4'h0, a[11:0], 4'h0} ^ 32'h5a5a_c3c3;
	return {w, ~w, w ^ 32'h0f0f_0f0f, w + 32'd1};
endfunction

function automatic lc3b_line byte_merge(input lc3b_line base, input lc3b_line data,
		input lc3b_line_mask sel);
	lc3b_line r;
	r = base;
	for (int b = 0; b < 16; b++) begin
		if (sel[b])
			r[8*b +: 8] = data[8*b +: 8];
	end
	return r;
endfunction

function automatic lc3b_line rand_line();
	return {$urandom, $urandom, $urandom, $urandom};
endfunction

function automatic int plru_victim();
	return plru[0] ? (2 + int'(plru[2])) : int'(plru[1]);
endfunction

// Touching a way turns the tree away from it
task automatic plru_touch(input int w);
	if (w < 2) begin
		plru[0] = 1'b1;
		plru[1] = ~w[0];
	end else begin
		plru[0] = 1'b0;
		plru[2] = ~w[0];
	end
endtask

function automatic int find_way(input lc3b_line_addr adr);
	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		if (buf_valid[i] && buf_tag[i] == adr)
			return i;
	end
	return -1;
endfunction

function automatic int free_way();
	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		if (!buf_valid[i])
			return i;
	end
	return plru_victim();
endfunction

task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
	chk_name = name;
	chk_got = got;
	chk_exp = exp;
	chk_en = 1'b1;
	checks++;
	@(posedge clk);
	#1 chk_en = 1'b0;
endtask

task automatic report_timeout(input string what);
	$display("Timeout while waiting for %s", what);
	timed_out = 1'b1;
endtask

task automatic cpu_access(input logic we, input lc3b_line_addr adr, input lc3b_line_mask sel,
		input lc3b_line data, output lc3b_line rdata, output logic mem_seen);
	int n;
	n = 0;
	mem_seen = 1'b0;
	@(posedge clk);
	#1;
	cpu_cyc = 1'b1;
	cpu_stb = 1'b1;
	cpu_we = we;
	cpu_adr = adr;
	cpu_sel = sel;
	cpu_dat_w = data;
	do begin
		@(negedge clk);
		n++;
		if (mem_cyc)
			mem_seen = 1'b1;
	end while (!cpu_ack && n < 300);
	if (!cpu_ack)
		report_timeout("cpu_ack");
	rdata = cpu_dat_r;
	@(posedge clk);
	#1;
	cpu_cyc = 1'b0;
	cpu_stb = 1'b0;
	cpu_we = 1'b0;
endtask

task automatic cfg_access(input logic we, input logic [1:0] adr, input logic [31:0] data,
		output logic [31:0] rdata);
	int n;
	n = 0;
	@(posedge clk);
	#1;
	cfg_cyc = 1'b1;
	cfg_stb = 1'b1;
	cfg_we = we;
	cfg_adr = adr;
	cfg_dat_w = data;
	do begin
		@(negedge clk);
		n++;
	end while (!cfg_ack && n < 20);
	if (!cfg_ack)
		report_timeout("cfg_ack");
	rdata = cfg_dat_r;
	@(posedge clk);
	#1;
	cfg_cyc = 1'b0;
	cfg_stb = 1'b0;
	cfg_we = 1'b0;
endtask

// Updates the model and returns the memory write it predicts, if any
task automatic model_write(input lc3b_line_addr adr, input lc3b_line_mask sel,
		input lc3b_line data, output logic wb, output lc3b_line_addr wb_adr,
		output lc3b_line wb_line);
	int w;
	wb = 1'b0;
	wb_adr = '0;
	wb_line = '0;
	w = find_way(adr);
	if (w >= 0) begin
		buf_line[w] = byte_merge(buf_line[w], data, sel);
		plru_touch(w);
		model_hits++;
	end else if (!model_enable) begin
		model_mem[adr] = byte_merge(model_mem[adr], data, sel);
		touched.push_back(adr);
		wb = 1'b1;	// Bypass write goes straight through
		wb_adr = adr;
		wb_line = model_mem[adr];
	end else begin
		w = free_way();
		if (&buf_valid) begin
			wb = 1'b1;
			wb_adr = buf_tag[w];
			wb_line = buf_line[w];
			model_mem[wb_adr] = wb_line;
			touched.push_back(wb_adr);
		end
		buf_tag[w] = adr;
		buf_line[w] = byte_merge(model_mem[adr], data, sel);
		buf_valid[w] = 1'b1;
		plru_touch(w);
	end
endtask

task automatic write_check(input lc3b_line_addr adr, input lc3b_line_mask sel);
	lc3b_line data;
	lc3b_line rd;
	lc3b_line_addr wb_adr;
	lc3b_line wb_line;
	logic wb;
	logic seen;
	int log_before;
	data = rand_line();
	log_before = pmem_i.wr_log.size();
	model_write(adr, sel, data, wb, wb_adr, wb_line);
	cpu_access(1'b1, adr, sel, data, rd, seen);
	compare("mem write count", 128'(pmem_i.wr_log.size() - log_before), 128'(wb));
	if (wb && pmem_i.wr_log.size() > log_before) begin
		compare("mem_adr", 128'(pmem_i.wr_log[log_before]), 128'(wb_adr));
		compare("mem_dat_w", pmem_i.mem[wb_adr], wb_line);
	end
endtask

task automatic read_check(input lc3b_line_addr adr, input logic expect_quiet);
	lc3b_line rd;
	lc3b_line exp;
	logic seen;
	int w;
	w = find_way(adr);
	if (w >= 0) begin
		exp = buf_line[w];
		plru_touch(w);
		model_hits++;
	end else begin
		exp = model_mem[adr];
	end
	cpu_access(1'b0, adr, '0, '0, rd, seen);
	compare("cpu_dat_r", rd, exp);
	if (expect_quiet)
		compare("mem_cyc", 128'(seen), 128'(0));
endtask

task automatic end_case(input int n, input string name);
	if (errors == case_err) begin
		$display("case %0d %s ok", n, name);
	end else begin
		$display("case %0d %s bad", n, name);
		bad_cases++;
	end
	case_err = errors;
endtask

initial begin
	logic [31:0] r;
	lc3b_line_mask sels [4];
	int n;
	void'($urandom(20423));
	clk = 1'b0;
	arst_n = 1'b0;
	cpu_cyc = 1'b0;
	cpu_stb = 1'b0;
	cpu_we = 1'b0;
	cpu_adr = '0;
	cpu_sel = '0;
	cpu_dat_w = '0;
	cfg_cyc = 1'b0;
	cfg_stb = 1'b0;
	cfg_we = 1'b0;
	cfg_adr = '0;
	cfg_dat_w = '0;
	chk_en = 1'b0;
	chk_got = '0;
	chk_exp = '0;
	errors = 0;
	checks = 0;
	bad_cases = 0;
	case_err = 0;
	timed_out = 1'b0;
	for (int a = 0; a < (1 << `EWB_ADDR_W); a++)
		model_mem[a] = mem_pattern(a);
	buf_valid = '0;
	plru = '0;
	model_enable = 1'b1;
	model_hits = 0;
	sels = '{16'h00ff, 16'h0f0f, 16'hf000, 16'hffff};
	repeat (16) @(posedge clk);
	#1 arst_n = 1'b1;

	for (int i = 0; i < 4; i++) begin
		write_check(12'h010 + 12'(i), sels[i]);
		read_check(12'h010 + 12'(i), 1'b0);
	end
	write_check(12'h011, 16'h3c00);	// Merge into a buffered line
	read_check(12'h011, 1'b0);
	end_case(1, "partial writes");

	write_check(12'h020, 16'hffff);
	read_check(12'h020, 1'b0);
	write_check(12'h021, 16'h0ff0);
	read_check(12'h021, 1'b0);
	end_case(2, "eviction");

	read_check(12'h020, 1'b1);
	read_check(12'h300, 1'b0);
	end_case(3, "reads");

	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		if (buf_valid[i]) begin
			model_mem[buf_tag[i]] = buf_line[i];
			touched.push_back(buf_tag[i]);
		end
	end
	buf_valid = '0;
	cfg_access(1'b1, REG_CTRL, 32'h3, r);
	n = 0;
	do begin
		cfg_access(1'b0, REG_STATUS, '0, r);
		n++;
	end while (r[4] && n < 100);
	if (r[4])
		report_timeout("busy to fall");
	compare("valid_mask", 128'(r[3:0]), 128'(0));
	foreach (touched[i])
		compare("pmem line", pmem_i.mem[touched[i]], model_mem[touched[i]]);
	end_case(4, "flush");

	cfg_access(1'b1, REG_CTRL, 32'h0, r);
	model_enable = 1'b0;
	write_check(12'h400, 16'h00f0);
	write_check(12'h401, 16'hffff);
	cfg_access(1'b0, REG_STATUS, '0, r);
	compare("valid_mask", 128'(r[3:0]), 128'(0));
	cfg_access(1'b1, REG_CTRL, 32'h1, r);
	model_enable = 1'b1;
	end_case(5, "bypass");

	cfg_access(1'b0, REG_HITS, '0, r);
	compare("hit_count", 128'(r), 128'(model_hits));
	cfg_access(1'b1, REG_HITS, '0, r);
	cfg_access(1'b0, REG_HITS, '0, r);
	compare("hit_count", 128'(r), 128'(0));
	end_case(6, "hit counter");

	$display("cases 6, bad %0d, checks %0d, errors %0d", bad_cases, checks, errors);
	if (errors == 0)
		$display("test passed");
	else
		$display("test failed");
	$finish;
end

endmodule: eviction_tb

/* testbench/pmem_model.sv */
`timescale 1ns/1ns

module pmem_model import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic we,
	input lc3b_line_addr adr,
	input lc3b_line_mask sel,
	input lc3b_line dat_w,
	output lc3b_line dat_r,
	output logic ack
);

lc3b_line mem [1 << $bits(lc3b_line_addr)];
lc3b_line_addr wr_log [$];	// Address of every write, in order
logic pending;
int wait_left;

// Each word mixes the full line address
function automatic lc3b_line fill_line(input int a);
	logic [31:0] w;
	w = {a[11:0], 4'h0, a[11:0], 4'h0} ^ 32'h5a5a_c3c3;
	return {w, ~w, w ^ 32'h0f0f_0f0f, w + 32'd1};
endfunction

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		ack <= 1'b0;
		pending <= 1'b0;
		wait_left <= 0;
		dat_r <= '0;
		for (int a = 0; a < (1 << $bits(lc3b_line_addr)); a++)
			mem[a] <= fill_line(a);
	end else begin
		ack <= 1'b0;
		if (cyc && stb && !ack && !pending) begin
			pending <= 1'b1;
			wait_left <= int'($urandom_range(2, 0));
		end else if (pending) begin
			if (wait_left == 0) begin
				pending <= 1'b0;
				ack <= 1'b1;
				if (we) begin
					for (int b = 0; b < $bits(lc3b_line_mask); b++) begin
						if (sel[b])
							mem[adr][8*b +: 8] <= dat_w[8*b +: 8];
					end
					wr_log.push_back(adr);
				end else begin
					dat_r <= mem[adr];
				end
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end
end

endmodule: pmem_model

/* source/victim_buffer_top.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module victim_buffer_top import lc3b_types::*; (
	input logic clk,
	input logic arst_n,

	// CPU side
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input lc3b_line_addr cpu_adr,
	input lc3b_line_mask cpu_sel,
	input lc3b_line cpu_dat_w,
	output lc3b_line cpu_dat_r,
	output logic cpu_ack,

	// Physical memory
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output lc3b_line_addr mem_adr,
	output lc3b_line_mask mem_sel,
	output lc3b_line mem_dat_w,
	input lc3b_line mem_dat_r,
	input logic mem_ack,

	// Registers
	input logic cfg_cyc,
	input logic cfg_stb,
	input logic cfg_we,
	input logic [`EWB_REG_ADR_W-1:0] cfg_adr,
	input logic [`EWB_REG_W-1:0] cfg_dat_w,
	output logic [`EWB_REG_W-1:0] cfg_dat_r,
	output logic cfg_ack
);

logic enable;
logic flush_start;
logic busy;
logic [`EWB_ENTRIES-1:0] valid_mask;
logic hit_pulse;

eviction_wb evict_i (.*);

eviction_regs regs_i (.*);

endmodule: victim_buffer_top

/* source/eviction_regs.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_regs import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic cfg_cyc,
	input logic cfg_stb,
	input logic cfg_we,
	input logic [`EWB_REG_ADR_W-1:0] cfg_adr,
	input logic [`EWB_REG_W-1:0] cfg_dat_w,
	output logic [`EWB_REG_W-1:0] cfg_dat_r,
	output logic cfg_ack,
	input logic busy,
	input logic [`EWB_ENTRIES-1:0] valid_mask,
	input logic hit_pulse,
	output logic enable,
	output logic flush_start
);

logic cfg_req;
logic cfg_wr;
logic [`EWB_REG_W-1:0] hit_count;

assign cfg_req = cfg_cyc && cfg_stb && !cfg_ack;	// Held STB is taken once
assign cfg_wr = cfg_req && cfg_we;

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		cfg_ack <= 1'b0;
		enable <= 1'b1;
		flush_start <= 1'b0;
		hit_count <= '0;
	end else begin
		cfg_ack <= cfg_req;
		flush_start <= 1'b0;
		if (cfg_wr && cfg_adr == REG_CTRL) begin
			enable <= cfg_dat_w[`EWB_CTRL_ENABLE];
			flush_start <= cfg_dat_w[`EWB_CTRL_FLUSH];
		end
		if (cfg_wr && cfg_adr == REG_HITS)
			hit_count <= '0;
		else if (hit_pulse && !(&hit_count))
			hit_count <= hit_count + 1'b1;	// Saturates
	end
end

always_ff @(posedge clk) begin
	if (cfg_req) begin
		case (cfg_adr)
		REG_CTRL: cfg_dat_r <= `EWB_REG_W'(enable);	// Flush bit reads 0
		REG_STATUS: cfg_dat_r <= `EWB_REG_W'({busy, valid_mask});
		REG_HITS: cfg_dat_r <= hit_count;
		default: cfg_dat_r <= '0;
		endcase
	end
end

flush_pulse: assert property (@(posedge clk) disable iff (!arst_n)
	flush_start |=> !flush_start);

endmodule: eviction_regs

/* eviction_wb/eviction_wb.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_wb import lc3b_types::*; (
	input logic clk,
	input logic arst_n,

	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input lc3b_line_addr cpu_adr,
	input lc3b_line_mask cpu_sel,
	input lc3b_line cpu_dat_w,
	output lc3b_line cpu_dat_r,
	output logic cpu_ack,

	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output lc3b_line_addr mem_adr,
	output lc3b_line_mask mem_sel,
	output lc3b_line mem_dat_w,
	input lc3b_line mem_dat_r,
	input logic mem_ack,

	input logic enable,
	input logic flush_start,
	output logic busy,
	output logic [`EWB_ENTRIES-1:0] valid_mask,
	output logic hit_pulse
);

logic [`EWB_ENTRIES-1:0] load_entry;
logic merge_cpu;
logic clear_valid;
logic lru_touch;
logic wb_sel_lru;
ewb_way_t flush_idx;
logic fwd_sel;
logic hit;
ewb_way_t hit_way;
logic full;
ewb_way_t lru_way;

// Bypass writes keep the CPU byte lanes, all other traffic moves whole lines
assign mem_sel = (fwd_sel && mem_we) ? cpu_sel : '1;

eviction_wb_datapath datapath_i (.*);

eviction_wb_control control_i (.*);

endmodule: eviction_wb

/* eviction_wb/eviction_wb_control.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_wb_control import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input lc3b_line_mask cpu_sel,
	input logic mem_ack,
	input logic enable,
	input logic flush_start,
	input logic hit,
	input ewb_way_t hit_way,
	input logic full,
	input logic [`EWB_ENTRIES-1:0] valid_mask,
	input ewb_way_t lru_way,
	output logic cpu_ack,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic [`EWB_ENTRIES-1:0] load_entry,
	output logic merge_cpu,
	output logic clear_valid,
	output logic lru_touch,
	output logic wb_sel_lru,
	output ewb_way_t flush_idx,
	output logic busy,
	output logic hit_pulse,
	output logic fwd_sel
);

localparam int WAY_W = $bits(ewb_way_t);

ewb_state_e state;
ewb_state_e state_next;
ewb_way_t flush_idx_next;
ewb_way_t alloc_way;
logic ack_q;
logic flush_pend;
logic cpu_req;
logic full_sel;
logic [WAY_W:0] first_valid;	// {found, way}
logic [WAY_W:0] after_valid;

// Lowest valid way at or above from
function automatic logic [WAY_W:0] find_valid(input logic [`EWB_ENTRIES-1:0] mask,
		input int from);
	logic [WAY_W:0] found;
	found = '0;
	for (int i = `EWB_ENTRIES - 1; i >= 0; i--) begin
		if (mask[i] && i >= from)
			found = {1'b1, ewb_way_t'(i)};
	end
	return found;
endfunction

assign first_valid = find_valid(valid_mask, 0);
assign after_valid = find_valid(valid_mask, int'(flush_idx) + 1);

// Lowest free way, PLRU victim when full
always_comb begin
	alloc_way = lru_way;
	for (int i = `EWB_ENTRIES - 1; i >= 0; i--) begin
		if (!valid_mask[i])
			alloc_way = ewb_way_t'(i);
	end
end

assign cpu_req = cpu_cyc && cpu_stb && !ack_q;	// Not the request being acked
assign full_sel = &cpu_sel;

always_comb begin
	state_next = state;
	flush_idx_next = flush_idx;
	load_entry = '0;
	merge_cpu = 1'b0;
	clear_valid = 1'b0;
	lru_touch = 1'b0;
	case (state)
	IDLE: begin
		if (flush_pend) begin
			state_next = FLUSH_SCAN;
		end else if (cpu_req) begin
			if (hit)
				state_next = CPU_ACK;
			else if (!cpu_we)
				state_next = FILL_READ;
			else if (!enable)
				state_next = BYPASS;
			else if (full)
				state_next = WB_LRU;
			else if (full_sel)
				state_next = CPU_ACK;
			else
				state_next = FILL_READ;
		end
	end
	CPU_ACK: begin
		if (cpu_we) begin
			load_entry[hit ? hit_way : alloc_way] = 1'b1;
			merge_cpu = 1'b1;
		end
		lru_touch = 1'b1;
		state_next = IDLE;
	end
	WB_LRU: begin
		if (mem_ack)
			state_next = full_sel ? CPU_ACK : FILL_READ;
	end
	FILL_READ: begin
		if (mem_ack) begin
			if (cpu_we) begin
				load_entry[alloc_way] = 1'b1;	// Memory line under the CPU bytes
				lru_touch = 1'b1;
			end
			state_next = IDLE;
		end
	end
	BYPASS: begin
		if (mem_ack)
			state_next = IDLE;
	end
	FLUSH_SCAN: begin
		if (first_valid[WAY_W]) begin
			flush_idx_next = first_valid[WAY_W-1:0];
			state_next = FLUSH_WRITE;
		end else begin
			clear_valid = 1'b1;
			state_next = IDLE;
		end
	end
	FLUSH_WRITE: begin
		if (mem_ack) begin
			if (after_valid[WAY_W]) begin
				flush_idx_next = after_valid[WAY_W-1:0];
			end else begin
				clear_valid = 1'b1;
				state_next = IDLE;
			end
		end
	end
	default: state_next = IDLE;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		state <= IDLE;
		flush_idx <= '0;
		ack_q <= 1'b0;
		flush_pend <= 1'b0;
	end else begin
		state <= state_next;
		flush_idx <= flush_idx_next;
		ack_q <= (state == CPU_ACK);
		if (flush_start && !busy)
			flush_pend <= 1'b1;
		else if (state == IDLE)
			flush_pend <= 1'b0;
	end
end

assign mem_cyc = state inside {WB_LRU, FILL_READ, BYPASS, FLUSH_WRITE};
assign mem_stb = mem_cyc;
assign mem_we = state inside {WB_LRU, BYPASS, FLUSH_WRITE};
assign wb_sel_lru = (state == WB_LRU);
assign fwd_sel = state inside {FILL_READ, BYPASS};
assign cpu_ack = ack_q || (fwd_sel && mem_ack);	// Forwarded data is valid only with mem_ack
assign busy = flush_pend || (state inside {WB_LRU, FILL_READ, BYPASS, FLUSH_SCAN, FLUSH_WRITE});
assign hit_pulse = (state == CPU_ACK) && hit;

cpu_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
	cpu_ack |=> !cpu_ack);

// Memory request held until acked
mem_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
	mem_stb && !mem_ack |=> mem_cyc && mem_stb && $stable(mem_we) && $stable(wb_sel_lru));

// One load at a time, into a free way unless it hits or the buffer is full
load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
	$onehot0(load_entry) && ((load_entry & valid_mask) == '0 || hit || full));

endmodule: eviction_wb_control

/* eviction_wb/eviction_wb_datapath.sv */
`timescale 1ns/1ns
`include "eviction_macros.svh"

module eviction_wb_datapath import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input lc3b_line_addr cpu_adr,
	input lc3b_line_mask cpu_sel,
	input lc3b_line cpu_dat_w,
	input lc3b_line mem_dat_r,
	input logic [`EWB_ENTRIES-1:0] load_entry,
	input logic merge_cpu,
	input logic clear_valid,
	input logic lru_touch,
	input logic wb_sel_lru,
	input ewb_way_t flush_idx,
	input logic fwd_sel,
	output logic hit,
	output ewb_way_t hit_way,
	output logic full,
	output logic [`EWB_ENTRIES-1:0] valid_mask,
	output ewb_way_t lru_way,
	output lc3b_line cpu_dat_r,
	output lc3b_line_addr mem_adr,
	output lc3b_line mem_dat_w
);

lc3b_line_addr tags [`EWB_ENTRIES];
lc3b_line lines [`EWB_ENTRIES];
logic [`EWB_ENTRIES-1:0] valid;
logic [`EWB_ENTRIES-1:0] hit_vec;
logic [2:0] plru;	// [0] root, [1] ways 0/1, [2] ways 2/3
ewb_way_t touch_way;
ewb_way_t wb_idx;

function automatic lc3b_line merge_bytes(input lc3b_line base, input lc3b_line wdata,
		input lc3b_line_mask sel);
	lc3b_line result;
	result = base;
	for (int b = 0; b < $bits(lc3b_line_mask); b++) begin
		if (sel[b])
			result[8*b +: 8] = wdata[8*b +: 8];
	end
	return result;
endfunction

always_comb begin
	hit_way = '0;
	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		hit_vec[i] = valid[i] && (tags[i] == cpu_adr);
		if (hit_vec[i])
			hit_way = ewb_way_t'(i);
	end
end

assign hit = |hit_vec;
assign full = &valid;
assign valid_mask = valid;

// A load names its own way, a plain read hit touches the hit way
always_comb begin
	touch_way = hit_way;
	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		if (load_entry[i])
			touch_way = ewb_way_t'(i);
	end
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		valid <= '0;
		plru <= '0;
	end else begin
		if (clear_valid)
			valid <= '0;
		else
			valid <= valid | load_entry;
		if (lru_touch) begin
			// Point the tree at the other half and the sibling
			if (!touch_way[1]) begin
				plru[0] <= 1'b1;
				plru[1] <= ~touch_way[0];
			end else begin
				plru[0] <= 1'b0;
				plru[2] <= ~touch_way[0];
			end
		end
	end
end

assign lru_way = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};

always_ff @(posedge clk) begin
	for (int i = 0; i < `EWB_ENTRIES; i++) begin
		if (load_entry[i]) begin
			tags[i] <= cpu_adr;
			lines[i] <= merge_bytes(merge_cpu ? lines[i] : mem_dat_r, cpu_dat_w, cpu_sel);
		end
	end
end

assign wb_idx = wb_sel_lru ? lru_way : flush_idx;

// Forwarded requests use the CPU address and data directly
assign mem_adr = fwd_sel ? cpu_adr : tags[wb_idx];
assign mem_dat_w = fwd_sel ? cpu_dat_w : lines[wb_idx];
assign cpu_dat_r = fwd_sel ? mem_dat_r : lines[hit_way];

endmodule: eviction_wb_datapath

/* common/lc3b_types.sv */
package lc3b_types;

`include "eviction_macros.svh"

typedef logic [`EWB_ADDR_W-1:0] lc3b_line_addr;	// Word address bits 15:4
typedef logic [`EWB_LINE_W-1:0] lc3b_line;
typedef logic [`EWB_LINE_W/8-1:0] lc3b_line_mask;	// One bit per byte lane
typedef logic [$clog2(`EWB_ENTRIES)-1:0] ewb_way_t;

typedef enum logic [2:0] {
	IDLE,
	CPU_ACK,	// Buffer access, ack follows
	WB_LRU,	// Write back the PLRU victim
	FILL_READ,	// Read miss, or partial write miss that needs the rest of the line
	BYPASS,
	FLUSH_SCAN,
	FLUSH_WRITE
} ewb_state_e;

// Word offsets on the register port
typedef enum logic [`EWB_REG_ADR_W-1:0] {
	REG_CTRL = `EWB_REG_CTRL,
	REG_STATUS = `EWB_REG_STATUS,
	REG_HITS = `EWB_REG_HITS
} ewb_reg_e;

endpackage: lc3b_types

/* common/eviction_macros.svh */
`ifndef EVICTION_MACROS_SVH
`define EVICTION_MACROS_SVH

`define EWB_ENTRIES 4
`define EWB_LINE_W 128
`define EWB_ADDR_W 12

// Register port
`define EWB_REG_W 32
`define EWB_REG_ADR_W 2
`define EWB_REG_CTRL 2'd0
`define EWB_REG_STATUS 2'd1
`define EWB_REG_HITS 2'd2

// REG_CTRL bits
`define EWB_CTRL_ENABLE 0
`define EWB_CTRL_FLUSH 1

`endif
